//--- list.f
+incdir+design
design/pal_timing_pkg.sv
design/pal_color_pkg.sv
design/pal_sync_gen.sv
design/pal_chroma_mod.sv
design/pal_cvbs_mixer.sv
design/pal_encoder.sv
tests/tb_clock_gen.sv
tests/pal_checker.sv
tests/pal_encoder_tb.sv

//--- Makefile
# Verilator flow for the PAL encoder testbench

VERILATOR ?= verilator
TOP       ?= pal_encoder_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/pal_encoder_tb.sv
/*
 * PAL encoder testbench: stimulus table applied field by field, with a
 * reference timing model that supplies the expected levels
 */
`include "pal_defs.svh"

module pal_encoder_tb
    import pal_timing_pkg::*, pal_color_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS         = 6;
    localparam int FIELD_HALF_LINES = 625;

    // name, colour, field alternation, strobes per line, expected Y
    string    row_name   [NUM_ROWS] = '{"black_plain", "white_plain", "red_fast",
                                        "green_alt", "blue_alt", "mixed_alt"};
    palette_t row_color  [NUM_ROWS] = '{8'h00, 8'hff, 8'h07, 8'h38, 8'hc0, 8'h5a};
    logic     row_alt    [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
    int       row_strobe [NUM_ROWS] = '{96, 64, 768, 96, 48, 128};
    int       row_y      [NUM_ROWS] = '{0, 17, 5, 10, 1, 6};

    logic        clk24;
    logic        arst_n;
    logic        vsync_in;
    logic        chroma_ce;
    logic        field_alt_en;
    palette_t    color_in;
    logic        sync_n;
    level_t      luma;
    level_t      chroma;
    level_t      cvbs;

    // reference model state
    logic        m_vs_q;
    pixel_t      m_px;
    linepos_t    m_lp;
    halfline_t   m_hl;
    field_t      m_field;
    phase_t      m_phase;
    logic        m_blank;
    logic        m_burst;
    logic        m_zone;
    logic        m_alt;
    logic [2:0]  m_idx;

    logic        exp_sync_n;
    level_t      exp_luma;
    level_t      exp_chroma;
    level_t      exp_cvbs;
    logic        chk_color;
    logic        hold;
    int          cur_y      = 0;
    int          ce_gap     = 16;
    int          ce_wait    = 0;
    logic [31:0] lfsr_state = 32'h4176259b;
    logic        timed_out  = 1'b0;

    tb_clock_gen i_clock_gen (
        .clk24  (clk24),
        .arst_n (arst_n)
    );

    pal_encoder i_dut (
        .clk24        (clk24),
        .arst_n       (arst_n),
        .vsync_in     (vsync_in),
        .chroma_ce    (chroma_ce),
        .field_alt_en (field_alt_en),
        .color_in     (color_in),
        .sync_n       (sync_n),
        .luma         (luma),
        .chroma       (chroma),
        .cvbs         (cvbs)
    );

    pal_checker i_checker (
        .clk24      (clk24),
        .active     (!hold),
        .chk_color  (chk_color),
        .exp_sync_n (exp_sync_n),
        .exp_luma   (exp_luma),
        .exp_chroma (exp_chroma),
        .exp_cvbs   (exp_cvbs),
        .sync_n     (sync_n),
        .luma       (luma),
        .chroma     (chroma),
        .cvbs       (cvbs)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic int lfsr_bits(input int count);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < count; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    // top three bits of the burst sine, one entry per 45 degrees
    function automatic logic [2:0] sine_top(input logic [2:0] idx);
        case (idx)
            3'd0:    return 3'd2;
            3'd1:    return 3'd0;
            3'd2:    return 3'd0;
            3'd3:    return 3'd2;
            3'd4:    return 3'd6;
            3'd5:    return 3'd7;
            3'd6:    return 3'd7;
            default: return 3'd6;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // reference timing, restarted by the same vsync falling edge
    // ------------------------------------------------------------------------
    always_ff @(posedge clk24 or negedge arst_n) begin
        if (!arst_n) begin
            m_vs_q  <= 1'b0;
            m_px    <= '0;
            m_hl    <= '0;
            m_field <= '0;
            m_phase <= '0;
            m_blank <= 1'b0;
            m_burst <= 1'b0;
        end else begin
            m_vs_q <= vsync_in;
            if (m_vs_q && !vsync_in) begin
                m_px    <= '0;
                m_hl    <= '0;
                m_field <= m_field + 1'b1;
            end else if (m_px == `PAL_HALF_LINE - 1) begin
                m_px <= '0;
                m_hl <= m_hl + 1'b1;
            end else begin
                m_px <= m_px + 1'b1;
            end
            if (chroma_ce) begin
                m_phase <= m_phase + 1'b1;
            end
            m_blank <= (m_lp < `PAL_BLANK_END) || (m_lp > `PAL_BLANK_START) || m_zone;
            m_burst <= (m_lp >= `PAL_BURST_START + 1) &&
                       (m_lp <= `PAL_BURST_START + `PAL_BURST_LEN - 1);
        end
    end

    // expected levels from the model
    always_comb begin
        // odd half lines are the second half of a line
        m_lp   = linepos_t'(m_px) + (m_hl[0] ? linepos_t'(`PAL_HALF_LINE) : linepos_t'(0));
        m_zone = (m_hl <= `PAL_NARROW_LAST) || (m_hl >= `PAL_NARROW_FIRST);
        if (m_hl <= `PAL_BROAD_LAST) begin
            exp_sync_n = (m_px >= `PAL_BROAD_SYNC);
        end else if (m_zone) begin
            exp_sync_n = (m_px >= `PAL_NARROW_SYNC);
        end else begin
            exp_sync_n = (m_lp >= `PAL_NORMAL_SYNC);
        end
        m_alt     = m_hl[1] ^ (field_alt_en & m_field[0]);
        m_idx     = m_phase[3:1] + {2'b00, !m_alt};
        chk_color = 1'b1;
        if (!exp_sync_n) begin
            exp_luma   = level_t'(`PAL_V_SYNC);
            exp_chroma = level_t'(`PAL_CHROMA_MID);
            exp_cvbs   = level_t'(`PAL_V_SYNC);
        end else if (m_blank && m_burst) begin
            exp_luma   = level_t'(`PAL_V_REF);
            exp_chroma = level_t'(`PAL_CHROMA_MID - 4 + sine_top(m_idx));
            exp_cvbs   = level_t'(`PAL_V_REF + 4 - sine_top(m_idx));
        end else if (m_blank) begin
            exp_luma   = level_t'(`PAL_V_REF);
            exp_chroma = level_t'(`PAL_CHROMA_MID);
            exp_cvbs   = level_t'(`PAL_V_REF);
        end else begin
            // chroma only predicted for black
            exp_luma   = level_t'(`PAL_V_REF + cur_y);
            exp_chroma = level_t'(`PAL_CHROMA_MID);
            exp_cvbs   = level_t'(`PAL_V_REF);
            chk_color  = (color_in == 8'h00);
        end
    end

    // chroma_ce strobes with pseudo random gaps around the row spacing
    initial begin
        chroma_ce = 1'b0;
        forever begin
            @(negedge clk24);
            if (ce_wait == 0) begin
                chroma_ce = 1'b1;
                ce_wait   = ce_gap / 2 + lfsr_bits(5) % ce_gap;
            end else begin
                chroma_ce = 1'b0;
                ce_wait   = ce_wait - 1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // one table row: new inputs, vsync pulse, one full field checked
    // ------------------------------------------------------------------------
    task automatic run_row(input int r);
        field_t first_field;
        int     n;
        @(negedge clk24);
        @(negedge clk24);
        color_in     = row_color[r];
        field_alt_en = row_alt[r];
        ce_gap       = `PAL_LINE / row_strobe[r];
        cur_y        = row_y[r];
        first_field  = m_field;
        vsync_in     = 1'b1;
        i_checker.start_test(row_name[r]);
        @(negedge clk24);
        vsync_in = 1'b0;
        n = 0;
        while (m_field == first_field && n < 4) begin
            @(negedge clk24);
            n++;
        end
        if (m_field == first_field) begin
            i_checker.note_failure("timed out waiting for the field to start");
            timed_out = 1'b1;
        end else begin
            hold = 1'b0;
            n = 0;
            while (m_hl != FIELD_HALF_LINES && n < `PAL_HALF_LINE * (FIELD_HALF_LINES + 4)) begin
                @(negedge clk24);
                n++;
            end
            if (m_hl != FIELD_HALF_LINES) begin
                i_checker.note_failure("timed out waiting for the end of the field");
                timed_out = 1'b1;
            end
        end
        hold = 1'b1;
        i_checker.finish_test();
    endtask

    initial begin
        int n;
        vsync_in     = 1'b0;
        field_alt_en = 1'b0;
        color_in     = '0;
        hold         = 1'b1;
        n = 0;
        while (arst_n !== 1'b1 && n < 20) begin
            @(negedge clk24);
            n++;
        end
        if (arst_n !== 1'b1) begin
            i_checker.note_failure("reset was never released");
            i_checker.finish_test();
            timed_out = 1'b1;
        end
        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            run_row(r);
        end
        i_checker.report_counts();
        if (i_checker.total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tests/pal_checker.sv
/*
 * PAL encoder checker: compares the DUT levels with the expected levels
 * on the rising clock edge and keeps per-test and total counts
 */
module pal_checker import pal_color_pkg::*; (
    input  logic   clk24,
    input  logic   active,
    input  logic   chk_color,
    input  logic   exp_sync_n,
    input  level_t exp_luma,
    input  level_t exp_chroma,
    input  level_t exp_cvbs,
    input  logic   sync_n,
    input  level_t luma,
    input  level_t chroma,
    input  level_t cvbs
);
    timeunit 1ns;
    timeprecision 100ps;

    // mismatch lines printed per test before going quiet
    localparam int PRINT_LIMIT = 8;

    string test_name    = "reset";
    int    test_checks  = 0;
    int    test_errors  = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    total_checks = 0;
    int    total_errors = 0;

    task automatic compare(input string what, input logic [7:0] expected,
                           input logic [7:0] actual);
        test_checks++;
        if (actual !== expected) begin
            test_errors++;
            if (test_errors <= PRINT_LIMIT) begin
                $display("CHECK FAILED %s %s: expected %0d actual %0d at %0t ns",
                         test_name, what, expected, actual, $time);
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic note_failure(input string msg);
        test_errors++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic finish_test();
        tests_run++;
        total_checks += test_checks;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %-12s %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic report_counts();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errors);
    endtask

    // inputs move on the falling edge, levels are compared as the rising edge sees them
    always @(posedge clk24) begin
        if (active) begin
            compare("sync_n", {7'b0, exp_sync_n}, {7'b0, sync_n});
            compare("luma", exp_luma, luma);
            if (chk_color) begin
                compare("chroma", exp_chroma, chroma);
                compare("cvbs", exp_cvbs, cvbs);
            end
        end
    end

endmodule

//--- tests/tb_clock_gen.sv
/*
 * testbench clock and reset: 100 ns clock, reset held low for 8 cycles
 */
module tb_clock_gen (
    output logic clk24,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 8;

    initial begin
        clk24 = 1'b0;
        forever #50 clk24 = ~clk24;
    end

    // release on a falling edge, away from the DUT flops
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk24);
        @(negedge clk24);
        arst_n = 1'b1;
    end

endmodule

//--- design/pal_encoder.sv
/*
 * PAL composite encoder top: sync generator, chroma modulator and
 * output mixer
 */
module pal_encoder import pal_timing_pkg::*, pal_color_pkg::*; (
    input  logic     clk24,
    input  logic     arst_n,
    input  logic     vsync_in,
    input  logic     chroma_ce,
    input  logic     field_alt_en,
    input  palette_t color_in,
    output logic     sync_n,
    output level_t   luma,
    output level_t   chroma,
    output level_t   cvbs
);

    logic       blank;
    logic       burst;
    logic       alt_line;
    halfline_t  halfline;
    uv_t        uv;
    logic [2:0] burst_sin;

    pal_sync_gen i_sync_gen (
        .clk24        (clk24),
        .arst_n       (arst_n),
        .vsync_in     (vsync_in),
        .field_alt_en (field_alt_en),
        .sync_n       (sync_n),
        .blank        (blank),
        .burst        (burst),
        .alt_line     (alt_line),
        .halfline     (halfline)
    );

    pal_chroma_mod i_chroma_mod (
        .clk24     (clk24),
        .arst_n    (arst_n),
        .chroma_ce (chroma_ce),
        .alt_line  (alt_line),
        .color_in  (color_in),
        .uv        (uv),
        .burst_sin (burst_sin)
    );

    pal_cvbs_mixer i_cvbs_mixer (
        .sync_n    (sync_n),
        .blank     (blank),
        .burst     (burst),
        .color_in  (color_in),
        .uv        (uv),
        .burst_sin (burst_sin),
        .luma      (luma),
        .chroma    (chroma),
        .cvbs      (cvbs)
    );

endmodule

//--- design/pal_cvbs_mixer.sv
/*
 * PAL output mixer: luma weighting and the sync, blanking, burst and
 * active video level selection for luma, chroma and CVBS
 */
`include "pal_defs.svh"

module pal_cvbs_mixer import pal_color_pkg::*; (
    input  logic       sync_n,
    input  logic       blank,
    input  logic       burst,
    input  palette_t   color_in,
    input  uv_t        uv,
    input  logic [2:0] burst_sin,
    output level_t     luma,
    output level_t     chroma,
    output level_t     cvbs
);

    chan_t       chan_r;
    chan_t       chan_g;
    chan_t       chan_b;
    logic [13:0] y_sum;
    logic [6:0]  y_val;
    logic [4:0]  luma_act;
    logic [4:0]  chroma_act;
    logic [4:0]  cvbs_act;

    assign chan_r = {color_in[2:0], 1'b0};
    assign chan_g = {color_in[5:3], 1'b0};
    assign chan_b = {color_in[7:6], 2'b00};

    // Y ~ 0.299 R + 0.587 G + 0.114 B
    assign y_sum = 14'd24 * chan_r + 14'd47 * chan_g + 14'd9 * chan_b;
    assign y_val = y_sum[12:6];

    // active video levels, five bits wide
    assign luma_act   = 5'(`PAL_V_REF) + y_val[4:0];
    assign chroma_act = 5'(`PAL_CHROMA_MID) + uv[4:0];
    assign cvbs_act   = 5'(`PAL_V_REF) + y_val[4:0] - {uv[4], uv[4:1]};

    // ------------------------------------------------------------------------
    // level select, sync first, then blanking and burst
    // ------------------------------------------------------------------------
    always_comb begin
        if (!sync_n) begin
            luma   = level_t'(`PAL_V_SYNC);
            chroma = level_t'(`PAL_CHROMA_MID);
            cvbs   = level_t'(`PAL_V_SYNC);
        end else if (blank && burst) begin
            luma   = level_t'(`PAL_V_REF);
            chroma = level_t'(`PAL_CHROMA_MID - 4) + burst_sin;
            cvbs   = level_t'(`PAL_V_REF + 4) - burst_sin;
        end else if (blank) begin
            luma   = level_t'(`PAL_V_REF);
            chroma = level_t'(`PAL_CHROMA_MID);
            cvbs   = level_t'(`PAL_V_REF);
        end else begin
            luma   = {3'b000, luma_act};
            chroma = {3'b000, chroma_act};
            cvbs   = {3'b000, cvbs_act};
        end
    end

endmodule

//--- design/pal_chroma_mod.sv
/*
 * PAL chroma modulator: subcarrier phase counter, U/V coefficient table
 * with line-alternating phase sets, and the burst sine table
 */
module pal_chroma_mod import pal_color_pkg::*; (
    input  logic       clk24,
    input  logic       arst_n,
    input  logic       chroma_ce,
    input  logic       alt_line,
    input  palette_t   color_in,
    output uv_t        uv,
    output logic [2:0] burst_sin
);

    phase_t             phase;
    chan_t              chan_r;
    chan_t              chan_g;
    chan_t              chan_b;
    logic        [20:0] coef;
    logic signed [13:0] uv_sum;
    logic        [2:0]  sin_idx;
    logic        [7:0]  sin_val;

    // subcarrier phase, one step per strobe
    always_ff @(posedge clk24 or negedge arst_n) begin
        if (!arst_n) begin
            phase <= '0;
        end else if (chroma_ce) begin
            phase <= phase + 1'b1;
        end
    end

    // low channel bits stay zero
    assign chan_r = {color_in[2:0], 1'b0};
    assign chan_g = {color_in[5:3], 1'b0};
    assign chan_b = {color_in[7:6], 2'b00};

    // ------------------------------------------------------------------------
    // coefficient triples {r, g, b}, first set V at +90, second set V at -90
    // ------------------------------------------------------------------------
    always_comb begin
        case ({alt_line, phase})
            5'd0:    coef = {7'sd49, -7'sd41, -7'sd7};
            5'd1:    coef = {7'sd40, -7'sd46, 7'sd5};
            5'd2:    coef = {7'sd26, -7'sd45, 7'sd18};
            5'd3:    coef = {7'sd7, -7'sd36, 7'sd29};
            5'd4:    coef = {-7'sd11, -7'sd22, 7'sd34};
            5'd5:    coef = {-7'sd29, -7'sd5, 7'sd35};
            5'd6:    coef = {-7'sd42, 7'sd12, 7'sd30};
            5'd7:    coef = {-7'sd49, 7'sd29, 7'sd20};
            5'd8:    coef = {-7'sd49, 7'sd41, 7'sd7};
            5'd9:    coef = {-7'sd40, 7'sd46, -7'sd5};
            5'd10:   coef = {-7'sd26, 7'sd45, -7'sd18};
            5'd11:   coef = {-7'sd7, 7'sd36, -7'sd29};
            5'd12:   coef = {7'sd11, 7'sd22, -7'sd34};
            5'd13:   coef = {7'sd29, 7'sd5, -7'sd35};
            5'd14:   coef = {7'sd42, -7'sd12, -7'sd30};
            5'd15:   coef = {7'sd49, -7'sd29, -7'sd20};
            5'd16:   coef = {-7'sd49, 7'sd41, 7'sd7};
            5'd17:   coef = {-7'sd49, 7'sd29, 7'sd20};
            5'd18:   coef = {-7'sd42, 7'sd12, 7'sd30};
            5'd19:   coef = {-7'sd29, -7'sd5, 7'sd35};
            5'd20:   coef = {-7'sd11, -7'sd22, 7'sd34};
            5'd21:   coef = {7'sd7, -7'sd36, 7'sd29};
            5'd22:   coef = {7'sd26, -7'sd45, 7'sd18};
            5'd23:   coef = {7'sd40, -7'sd46, 7'sd5};
            5'd24:   coef = {7'sd49, -7'sd41, -7'sd7};
            5'd25:   coef = {7'sd49, -7'sd29, -7'sd20};
            5'd26:   coef = {7'sd42, -7'sd12, -7'sd30};
            5'd27:   coef = {7'sd29, 7'sd5, -7'sd35};
            5'd28:   coef = {7'sd11, 7'sd22, -7'sd34};
            5'd29:   coef = {-7'sd7, 7'sd36, -7'sd29};
            5'd30:   coef = {-7'sd26, 7'sd45, -7'sd18};
            default: coef = {-7'sd40, 7'sd46, -7'sd5};
        endcase
    end

    // weighted sum of the channels, channels taken as positive values
    assign uv_sum = $signed(coef[20:14]) * $signed({1'b0, chan_r})
                  + $signed(coef[13:7]) * $signed({1'b0, chan_g})
                  + $signed(coef[6:0]) * $signed({1'b0, chan_b});

    // two overlapping slices summed, keeps range without overflow
    assign uv = {1'b0, uv_sum[13:7]} + {1'b0, uv_sum[12:6]};

    // burst sine, one step ahead on the even lines
    assign sin_idx = phase[3:1] + {2'b00, ~alt_line};

    always_comb begin
        case (sin_idx)
            3'd0:    sin_val = 8'd91;
            3'd1:    sin_val = 8'd0;
            3'd2:    sin_val = 8'd0;
            3'd3:    sin_val = 8'd91;
            3'd4:    sin_val = 8'd218;
            3'd5:    sin_val = 8'd255;
            3'd6:    sin_val = 8'd255;
            default: sin_val = 8'd218;
        endcase
    end

    assign burst_sin = sin_val[7:5];

endmodule

//--- design/pal_sync_gen.sv
/*
 * PAL sync generator: half-line and pixel counters, field sync pulses,
 * registered blanking and colour burst windows
 */
`include "pal_defs.svh"

module pal_sync_gen import pal_timing_pkg::*; (
    input  logic      clk24,
    input  logic      arst_n,
    input  logic      vsync_in,
    input  logic      field_alt_en,
    output logic      sync_n,
    output logic      blank,
    output logic      burst,
    output logic      alt_line,
    output halfline_t halfline
);

    logic     vsync_q;
    logic     field_start;
    pixel_t   pixel;
    linepos_t linepos;
    field_t   field_cnt;
    logic     field_zone;

    // falling edge of the incoming frame strobe
    assign field_start = vsync_q & ~vsync_in;

    // ------------------------------------------------------------------------
    // counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk24 or negedge arst_n) begin
        if (!arst_n) begin
            vsync_q   <= 1'b0;
            pixel     <= '0;
            linepos   <= '0;
            halfline  <= '0;
            field_cnt <= '0;
        end else begin
            vsync_q <= vsync_in;
            if (field_start) begin
                pixel     <= '0;
                linepos   <= '0;
                halfline  <= '0;
                field_cnt <= field_cnt + 1'b1;
            end else begin
                if (pixel == `PAL_HALF_LINE - 1) begin
                    pixel    <= '0;
                    halfline <= halfline + 1'b1;
                end else begin
                    pixel <= pixel + 1'b1;
                end
                if (linepos == `PAL_LINE - 1) begin
                    linepos <= '0;
                end else begin
                    linepos <= linepos + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // sync pulse decode
    // ------------------------------------------------------------------------
    always_comb begin
        field_zone = 1'b1;
        if (halfline <= `PAL_BROAD_LAST) begin
            // broad pulses, sync held low for most of the half line
            sync_n = ~(pixel < `PAL_BROAD_SYNC);
        end else if (halfline <= `PAL_NARROW_LAST || halfline >= `PAL_NARROW_FIRST) begin
            // equalizing pulses
            sync_n = ~(pixel < `PAL_NARROW_SYNC);
        end else begin
            field_zone = 1'b0;
            sync_n     = ~(linepos < `PAL_NORMAL_SYNC);
        end
    end

    // blanking and burst windows, one cycle behind linepos
    always_ff @(posedge clk24 or negedge arst_n) begin
        if (!arst_n) begin
            blank <= 1'b0;
            burst <= 1'b0;
        end else begin
            blank <= (linepos < `PAL_BLANK_END) || (linepos > `PAL_BLANK_START) || field_zone;
            burst <= (linepos > `PAL_BURST_START) &&
                     (linepos < `PAL_BURST_START + `PAL_BURST_LEN);
        end
    end

    // line alternation, flipped every other field when enabled
    assign alt_line = halfline[1] ^ (field_alt_en & field_cnt[0]);

endmodule

//--- design/pal_color_pkg.sv
/*
 * PAL colour types: palette byte, expanded channels, chroma samples,
 * output levels and subcarrier phase
 */
package pal_color_pkg;

    // B in bits 7..6, G in 5..3, R in 2..0
    typedef logic [7:0] palette_t;

    // one colour channel expanded to four bits
    typedef logic [3:0] chan_t;

    // modulated chroma sample, two's complement
    typedef logic signed [7:0] uv_t;

    // level driven to the video DAC
    typedef logic [7:0] level_t;

    // subcarrier phase, 16 steps per cycle
    typedef logic [3:0] phase_t;

endpackage

//--- design/pal_timing_pkg.sv
/*
 * PAL timing types: line and field counters of the sync generator
 */
package pal_timing_pkg;

    // half-line number inside the field
    typedef logic [10:0] halfline_t;

    // position inside the current half line
    typedef logic [10:0] pixel_t;

    // position inside the full line, 0 .. 1535
    typedef logic [11:0] linepos_t;

    // field counter, bit 0 drives the field phase alternation
    typedef logic [2:0]  field_t;

endpackage

//--- design/pal_defs.svh
/*
 * PAL line geometry, sync pulse widths, window positions and output levels
 */
`ifndef PAL_DEFS_SVH
`define PAL_DEFS_SVH

// line geometry in clk24 cycles
`define PAL_HALF_LINE     768
`define PAL_LINE          1536

// sync pulse widths
`define PAL_NORMAL_SYNC   114
`define PAL_NARROW_SYNC   56
`define PAL_BROAD_SYNC    655

// field sync zone, in half lines
`define PAL_BROAD_LAST    4
`define PAL_NARROW_LAST   9
`define PAL_NARROW_FIRST  618

// blanking and colour burst windows, in line positions
`define PAL_BLANK_START   1496
`define PAL_BLANK_END     249
`define PAL_BURST_START   138
`define PAL_BURST_LEN     75

// output reference levels
`define PAL_V_SYNC        0
`define PAL_V_REF         8
`define PAL_CHROMA_MID    16

`endif
